//--- rtl/armExecPkg.sv
/* ARM execute unit shared definitions
   Widths, opcodes, shift types, host map and the data-processing word */
package armExecPkg;

	//********************
	// Widths
	localparam int dataW = 32;		// Datapath
	localparam int regAddrW = 4;	// R0 to R15
	localparam int addrW = 8;		// Host byte address

	//********************
	// Data-processing opcodes, ARM encoding
	localparam logic [3:0] opAnd = 4'h0;
	localparam logic [3:0] opEor = 4'h1;
	localparam logic [3:0] opSub = 4'h2;
	localparam logic [3:0] opRsb = 4'h3;
	localparam logic [3:0] opAdd = 4'h4;
	localparam logic [3:0] opAdc = 4'h5;
	localparam logic [3:0] opSbc = 4'h6;
	localparam logic [3:0] opRsc = 4'h7;
	localparam logic [3:0] opTst = 4'h8;	// Flags only
	localparam logic [3:0] opTeq = 4'h9;
	localparam logic [3:0] opCmp = 4'hA;
	localparam logic [3:0] opCmn = 4'hB;
	localparam logic [3:0] opOrr = 4'hC;
	localparam logic [3:0] opMov = 4'hD;
	localparam logic [3:0] opBic = 4'hE;
	localparam logic [3:0] opMvn = 4'hF;

	// Immediate shift types
	localparam logic [1:0] shLsl = 2'b00;
	localparam logic [1:0] shLsr = 2'b01;
	localparam logic [1:0] shAsr = 2'b10;
	localparam logic [1:0] shRor = 2'b11;	// Amount 0 is RRX

	//********************
	// Host register map
	localparam logic [addrW-1:0] addrInstr = 8'h00;		// Write issues
	localparam logic [addrW-1:0] addrStatus = 8'h04;	// NZCV in 31:28
	localparam logic [addrW-1:0] addrRegBase = 8'h40;	// R0, then step 4

	// AXI response codes
	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	// Data-processing word, bit 25 selects the low-field view
	typedef union packed
	{
		struct packed
		{
			logic [3:0] cond;			// Not evaluated
			logic [1:0] fixed;			// 00 for data processing
			logic iBit;					// Immediate operand
			logic [3:0] opcode;
			logic sBit;					// Set flags
			logic [regAddrW-1:0] rn;
			logic [regAddrW-1:0] rd;
			logic [3:0] rotate;			// Half the rotate amount
			logic [7:0] imm8;
		} dpImm;
		struct packed
		{
			logic [3:0] cond;
			logic [1:0] fixed;
			logic iBit;
			logic [3:0] opcode;
			logic sBit;
			logic [regAddrW-1:0] rn;
			logic [regAddrW-1:0] rd;
			logic [4:0] shAmt;
			logic [1:0] shType;
			logic regShift;				// Register-specified amount
			logic [regAddrW-1:0] rm;
		} dpReg;
	} instrWord_t;

endpackage

//--- rtl/armShifter.sv
/* Barrel shifter building the data-processing shifter operand
   Rotated immediate or Rm shifted by an immediate amount, with carry-out */
`timescale 1ns/1ps

module armShifter
(
	input  armExecPkg::instrWord_t instr,
	input  logic [armExecPkg::dataW-1:0] rmData,
	input  logic cin,									// Current C flag
	output logic [armExecPkg::dataW-1:0] operand,
	output logic shCarry
);
	import armExecPkg::*;

	logic [dataW-1:0] immExt;		// Zero-extended imm8
	logic [4:0] rotAmt;			// Twice the rotate field
	logic [4:0] shAmt;
	logic [2*dataW-1:0] rotImm;	// Doubled word, low half is the rotation
	logic [2*dataW-1:0] rotReg;
	logic [dataW:0] lslWide;		// Carry-out lands in top bit
	logic [dataW:0] lsrWide;		// Carry-out lands in bit 0
	logic [dataW:0] asrWide;

	assign immExt = {{(dataW-8){1'b0}}, instr.dpImm.imm8};
	assign rotAmt = {instr.dpImm.rotate, 1'b0};
	assign shAmt = instr.dpReg.shAmt;

	assign rotImm = {immExt, immExt} >> rotAmt;
	assign rotReg = {rmData, rmData} >> shAmt;
	assign lslWide = {1'b0, rmData} << shAmt;
	assign lsrWide = {rmData, 1'b0} >> shAmt;
	assign asrWide = $signed({rmData, 1'b0}) >>> shAmt;	// Sign fills from Rm[31]

	always_comb
	begin
		operand = rmData;	// LSL #0 passes Rm, keeps C
		shCarry = cin;
		if (instr.dpImm.iBit)
		begin
			operand = rotImm[dataW-1:0];
			shCarry = (instr.dpImm.rotate == 4'd0) ? cin : rotImm[dataW-1];
		end
		else
		begin
			case (instr.dpReg.shType)
				shLsl:
				begin
					if (shAmt != 5'd0)
					begin
						operand = lslWide[dataW-1:0];
						shCarry = lslWide[dataW];
					end
				end
				shLsr:
				begin
					operand = (shAmt == 5'd0) ? '0 : lsrWide[dataW:1];	// #0 means #32
					shCarry = (shAmt == 5'd0) ? rmData[dataW-1] : lsrWide[0];
				end
				shAsr:
				begin
					operand = (shAmt == 5'd0) ? {dataW{rmData[dataW-1]}} : asrWide[dataW:1];
					shCarry = (shAmt == 5'd0) ? rmData[dataW-1] : asrWide[0];
				end
				shRor:
				begin
					operand = (shAmt == 5'd0) ? {cin, rmData[dataW-1:1]} : rotReg[dataW-1:0];
					shCarry = (shAmt == 5'd0) ? rmData[0] : rotReg[dataW-1];	// RRX at #0
				end
				default:
				begin
					operand = rmData;
					shCarry = cin;
				end
			endcase
		end
	end

endmodule

//--- rtl/armAlu.sv
/* ARM data-processing ALU
   Sixteen operations on shifter operand and Rn, new NZCV and Rd write flag */
`timescale 1ns/1ps

module armAlu
(
	input  logic [armExecPkg::dataW-1:0] a,		// Shifter operand
	input  logic [armExecPkg::dataW-1:0] b,		// Rn
	input  logic [3:0] op,
	input  logic cin,							// C flag for ADC, SBC, RSC
	input  logic shCarry,						// C for logical ops
	input  logic vIn,							// V kept by logical ops
	output logic [armExecPkg::dataW-1:0] r,
	output logic [3:0] nzcv,
	output logic writesRd
);
	import armExecPkg::*;

	logic [dataW-1:0] addX;		// Adder left input
	logic [dataW-1:0] addY;		// Adder right input, inverted for subtract
	logic addC;
	logic [dataW:0] sum;
	logic isArith;
	logic cOut;
	logic vOut;

	//********************
	// Adder setup
	always_comb
	begin
		addX = b;
		addY = a;
		addC = 1'b0;
		isArith = 1'b1;
		case (op)
			opSub, opCmp:
			begin
				addY = ~a;		// Rn - operand
				addC = 1'b1;
			end
			opSbc:
			begin
				addY = ~a;
				addC = cin;		// Borrow is NOT C
			end
			opRsb:
			begin
				addX = a;		// Operand - Rn
				addY = ~b;
				addC = 1'b1;
			end
			opRsc:
			begin
				addX = a;
				addY = ~b;
				addC = cin;
			end
			opAdc:
				addC = cin;
			opAdd, opCmn:
				addC = 1'b0;	// Plain sum
			default:
				isArith = 1'b0;	// Logical, move, test
		endcase
	end

	assign sum = {1'b0, addX} + {1'b0, addY} + {{dataW{1'b0}}, addC};

	//********************
	// Result select
	always_comb
	begin
		case (op)
			opAnd, opTst:
				r = b & a;
			opEor, opTeq:
				r = b ^ a;
			opOrr:
				r = b | a;
			opMov:
				r = a;
			opBic:
				r = b & ~a;		// Rn AND NOT operand
			opMvn:
				r = ~a;
			default:
				r = sum[dataW-1:0];
		endcase
	end

	// Carry out of the adder is NOT borrow on subtract
	assign cOut = isArith ? sum[dataW] : shCarry;
	assign vOut = isArith ? ((addX[dataW-1] == addY[dataW-1]) && (sum[dataW-1] != addX[dataW-1]))
		: vIn;

	assign nzcv = {r[dataW-1], (r == '0), cOut, vOut};
	assign writesRd = !(op inside {opTst, opTeq, opCmp, opCmn});	// Compares set flags only

endmodule

//--- rtl/armRegFile.sv
/* Sixteen-entry general register file
   Three combinational read ports and one clocked write port */
`timescale 1ns/1ps

module armRegFile
(
	input  logic clk,
	input  logic arstN,
	input  logic [armExecPkg::regAddrW-1:0] rnAddr,
	input  logic [armExecPkg::regAddrW-1:0] rmAddr,
	input  logic [armExecPkg::regAddrW-1:0] hostRdAddr,
	output logic [armExecPkg::dataW-1:0] rnData,
	output logic [armExecPkg::dataW-1:0] rmData,
	output logic [armExecPkg::dataW-1:0] hostRdData,
	input  logic we,
	input  logic [armExecPkg::regAddrW-1:0] wAddr,
	input  logic [armExecPkg::dataW-1:0] wData
);
	import armExecPkg::*;

	logic [dataW-1:0] regs [2**regAddrW];	// R15 is a plain register

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < 2**regAddrW; i++)
				regs[i] <= '0;		// All registers read 0 after reset
		end
		else if (we)
			regs[wAddr] <= wData;
	end

	assign rnData = regs[rnAddr];			// First ALU source
	assign rmData = regs[rmAddr];			// Shifter source
	assign hostRdData = regs[hostRdAddr];	// Host read-back

endmodule

//--- rtl/armExecCore.sv
/* Execute core, decodes one data-processing word per issue
   Legality check, writeback of Rd and ownership of the NZCV flags */
`timescale 1ns/1ps

module armExecCore
(
	input  logic clk,
	input  logic arstN,
	input  logic issueValid,
	input  armExecPkg::instrWord_t issueInstr,
	input  logic hostRegWe,
	input  logic [armExecPkg::regAddrW-1:0] hostRegAddr,
	input  logic [armExecPkg::dataW-1:0] hostRegData,
	input  logic hostFlagsWe,
	input  logic [3:0] hostFlagsData,
	input  logic [armExecPkg::regAddrW-1:0] hostRdAddr,
	output logic [armExecPkg::dataW-1:0] hostRdData,
	output logic [3:0] flags,						// NZCV
	output logic done,
	output logic fault
);
	import armExecPkg::*;

	logic [dataW-1:0] rnData;
	logic [dataW-1:0] rmData;
	logic [dataW-1:0] operand;
	logic [dataW-1:0] aluR;
	logic shCarry;
	logic [3:0] aluNzcv;
	logic writesRd;
	logic illegal;
	logic regWe;
	logic [regAddrW-1:0] regWAddr;
	logic [dataW-1:0] regWData;

	// Refused words: not data processing, or register-specified shift
	assign illegal = (issueInstr.dpImm.fixed != 2'b00)
		|| (!issueInstr.dpImm.iBit && issueInstr.dpReg.regShift);
	assign done = issueValid;				// Single execute cycle
	assign fault = issueValid && illegal;

	// Write port shared with the host
	assign regWe = issueValid ? (!illegal && writesRd) : hostRegWe;
	assign regWAddr = issueValid ? issueInstr.dpImm.rd : hostRegAddr;
	assign regWData = issueValid ? aluR : hostRegData;

	armRegFile armRegFile_inst
	(
		.clk(clk),
		.arstN(arstN),
		.rnAddr(issueInstr.dpImm.rn),
		.rmAddr(issueInstr.dpReg.rm),
		.hostRdAddr(hostRdAddr),
		.rnData(rnData),
		.rmData(rmData),
		.hostRdData(hostRdData),
		.we(regWe),
		.wAddr(regWAddr),
		.wData(regWData)
	);

	armShifter armShifter_inst
	(
		.instr(issueInstr),
		.rmData(rmData),
		.cin(flags[1]),			// RRX and zero-rotate carry
		.operand(operand),
		.shCarry(shCarry)
	);

	armAlu armAlu_inst
	(
		.a(operand),
		.b(rnData),
		.op(issueInstr.dpImm.opcode),
		.cin(flags[1]),
		.shCarry(shCarry),
		.vIn(flags[0]),
		.r(aluR),
		.nzcv(aluNzcv),
		.writesRd(writesRd)
	);

	//********************
	// Status register
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			flags <= 4'b0000;
		else if (issueValid)
		begin
			if (!illegal && (issueInstr.dpImm.sBit || !writesRd))	// S set, or a compare
				flags <= aluNzcv;
		end
		else if (hostFlagsWe)
			flags <= hostFlagsData;
	end

endmodule

//--- rtl/armAxiSlave.sv
/* AXI4-Lite slave for the execute unit
   Maps host accesses onto registers, flags and instruction issue */
`timescale 1ns/1ps

module armAxiSlave
(
	input  logic clk,
	input  logic arstN,
	input  logic awValid,
	output logic awReady,
	input  logic [armExecPkg::addrW-1:0] awAddr,
	input  logic wValid,
	output logic wReady,
	input  logic [armExecPkg::dataW-1:0] wData,
	input  logic [armExecPkg::dataW/8-1:0] wStrb,		// Not decoded, writes are full-word
	output logic bValid,
	input  logic bReady,
	output logic [1:0] bResp,
	input  logic arValid,
	output logic arReady,
	input  logic [armExecPkg::addrW-1:0] arAddr,
	output logic rValid,
	input  logic rReady,
	output logic [armExecPkg::dataW-1:0] rData,
	output logic [1:0] rResp,
	output logic issueValid,
	output armExecPkg::instrWord_t issueInstr,
	output logic hostRegWe,
	output logic [armExecPkg::regAddrW-1:0] hostRegAddr,
	output logic [armExecPkg::dataW-1:0] hostRegData,
	output logic hostFlagsWe,
	output logic [3:0] hostFlagsData,
	output logic [armExecPkg::regAddrW-1:0] hostRdAddr,
	input  logic [armExecPkg::dataW-1:0] hostRdData,
	input  logic [3:0] flags,
	input  logic done,
	input  logic fault
);
	import armExecPkg::*;

	logic wrFire;
	logic wrIsInstr;
	logic wrIsStatus;
	logic wrIsReg;
	logic rdFire;
	logic rdHit;
	logic [dataW-1:0] rdMux;

	//********************
	// Write channel
	// Address and data taken together, blocked while a response is owed
	assign awReady = awValid && wValid && !bValid && !issueValid;
	assign wReady = awReady;
	assign wrFire = awValid && awReady;

	assign wrIsInstr = (awAddr == addrInstr);
	assign wrIsStatus = (awAddr == addrStatus);
	assign wrIsReg = ({awAddr[addrW-1:6], awAddr[1:0]} == {addrRegBase[addrW-1:6], 2'b00});

	assign hostRegWe = wrFire && wrIsReg;	// Lands at end of handshake cycle
	assign hostRegAddr = awAddr[regAddrW+1:2];
	assign hostRegData = wData;
	assign hostFlagsWe = wrFire && wrIsStatus;
	assign hostFlagsData = wData[dataW-1:dataW-4];

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			issueValid <= 1'b0;
			bValid <= 1'b0;
			bResp <= respOkay;
		end
		else
		begin
			issueValid <= wrFire && wrIsInstr;		// Execute next cycle
			if (done)
			begin
				bValid <= 1'b1;		// Response after execute
				bResp <= fault ? respSlvErr : respOkay;
			end
			else if (wrFire && !wrIsInstr)
			begin
				bValid <= 1'b1;
				bResp <= (wrIsStatus || wrIsReg) ? respOkay : respSlvErr;
			end
			else if (bValid && bReady)
				bValid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wrFire && wrIsInstr)
			issueInstr <= wData;		// Held through the issue cycle
	end

	//********************
	// Read channel
	assign arReady = !rValid;
	assign rdFire = arValid && arReady;
	assign hostRdAddr = arAddr[regAddrW+1:2];

	always_comb
	begin
		rdHit = 1'b1;
		if (arAddr == addrInstr)
			rdMux = issueInstr;		// Last issued word
		else if (arAddr == addrStatus)
			rdMux = {flags, {(dataW-4){1'b0}}};
		else if ({arAddr[addrW-1:6], arAddr[1:0]} == {addrRegBase[addrW-1:6], 2'b00})
			rdMux = hostRdData;
		else
		begin
			rdMux = '0;		// Unmapped
			rdHit = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			rValid <= 1'b0;
		else if (rdFire)
			rValid <= 1'b1;
		else if (rReady)
			rValid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (rdFire)
		begin
			rData <= rdMux;		// Captured at handshake
			rResp <= rdHit ? respOkay : respSlvErr;
		end
	end

endmodule

//--- rtl/armExecUnit.sv
/* ARM execute unit top level
   AXI4-Lite slave in front of the execute core */
`timescale 1ns/1ps

module armExecUnit
(
	input  logic clk,
	input  logic arstN,
	input  logic awValid,
	output logic awReady,
	input  logic [armExecPkg::addrW-1:0] awAddr,
	input  logic wValid,
	output logic wReady,
	input  logic [armExecPkg::dataW-1:0] wData,
	input  logic [armExecPkg::dataW/8-1:0] wStrb,
	output logic bValid,
	input  logic bReady,
	output logic [1:0] bResp,
	input  logic arValid,
	output logic arReady,
	input  logic [armExecPkg::addrW-1:0] arAddr,
	output logic rValid,
	input  logic rReady,
	output logic [armExecPkg::dataW-1:0] rData,
	output logic [1:0] rResp
);
	import armExecPkg::*;

	logic issueValid;
	instrWord_t issueInstr;
	logic hostRegWe;
	logic [regAddrW-1:0] hostRegAddr;
	logic [dataW-1:0] hostRegData;
	logic hostFlagsWe;
	logic [3:0] hostFlagsData;
	logic [regAddrW-1:0] hostRdAddr;
	logic [dataW-1:0] hostRdData;
	logic [3:0] flags;		// NZCV
	logic done;
	logic fault;

	armAxiSlave armAxiSlave_inst
	(
		.clk(clk), .arstN(arstN),
		.awValid(awValid), .awReady(awReady), .awAddr(awAddr),
		.wValid(wValid), .wReady(wReady), .wData(wData), .wStrb(wStrb),
		.bValid(bValid), .bReady(bReady), .bResp(bResp),
		.arValid(arValid), .arReady(arReady), .arAddr(arAddr),
		.rValid(rValid), .rReady(rReady), .rData(rData), .rResp(rResp),
		.issueValid(issueValid), .issueInstr(issueInstr),
		.hostRegWe(hostRegWe), .hostRegAddr(hostRegAddr), .hostRegData(hostRegData),
		.hostFlagsWe(hostFlagsWe), .hostFlagsData(hostFlagsData),
		.hostRdAddr(hostRdAddr), .hostRdData(hostRdData),
		.flags(flags), .done(done), .fault(fault)
	);

	armExecCore armExecCore_inst
	(
		.clk(clk), .arstN(arstN),
		.issueValid(issueValid), .issueInstr(issueInstr),
		.hostRegWe(hostRegWe), .hostRegAddr(hostRegAddr), .hostRegData(hostRegData),
		.hostFlagsWe(hostFlagsWe), .hostFlagsData(hostFlagsData),
		.hostRdAddr(hostRdAddr), .hostRdData(hostRdData),
		.flags(flags), .done(done), .fault(fault)
	);

endmodule

//--- dv/tbClock.sv
/* Testbench clock and reset generator
   8 ns clock, active-low reset held for two cycles */
`timescale 1ns/1ps

module tbClock
(
	output logic clk,
	output logic arstN
);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;		// 8 ns period
	end

	initial
	begin
		arstN = 1'b0;
		repeat (2) @(posedge clk);
		arstN <= 1'b1;				// Released after two rising edges
	end

endmodule

//--- dv/armExecTb.sv
/* Testbench for the ARM execute unit
   Table-driven instruction vectors over AXI4-Lite, plus register and status access */
`timescale 1ns/1ps

module armExecTb;
	import armExecPkg::*;

	localparam int numVec = 25;
	localparam int waitLimit = 100;				// Cycles per handshake wait
	localparam logic [3:0] rnIdx = 4'd1;
	localparam logic [3:0] rmIdx = 4'd2;
	localparam logic [3:0] rdIdx = 4'd3;
	localparam logic [31:0] rdInit = 32'h5A5A_5A5A;	// Rd preload kept by compares

	typedef struct packed
	{
		logic [31:0] rnVal;
		logic [31:0] rmVal;
		logic [3:0] nzcvIn;		// Flags before issue
		logic [1:0] fixed;		// Bits 27:26
		logic iBit;
		logic [3:0] op;
		logic sBit;
		logic [11:0] op2;		// Shifter operand field
		logic [31:0] expRd;
		logic [3:0] expNzcv;
		logic [1:0] expResp;
	} vec_t;

	logic clk;
	logic arstN;
	logic awValid;
	logic awReady;
	logic [7:0] awAddr;
	logic wValid;
	logic wReady;
	logic [31:0] wData;
	logic [3:0] wStrb;
	logic bValid;
	logic bReady;
	logic [1:0] bResp;
	logic arValid;
	logic arReady;
	logic [7:0] arAddr;
	logic rValid;
	logic rReady;
	logic [31:0] rData;
	logic [1:0] rResp;

	vec_t tbl [numVec];
	logic [31:0] shadow [16];		// Expected register contents
	integer seed;
	logic hung;						// Set once a handshake times out
	int errCount;
	int testCount;
	int failCount;
	int vecIdx;
	int rstWait;

	tbClock tbClock_inst
	(
		.clk(clk),
		.arstN(arstN)
	);

	armExecUnit armExecUnit_inst
	(
		.clk(clk), .arstN(arstN),
		.awValid(awValid), .awReady(awReady), .awAddr(awAddr),
		.wValid(wValid), .wReady(wReady), .wData(wData), .wStrb(wStrb),
		.bValid(bValid), .bReady(bReady), .bResp(bResp),
		.arValid(arValid), .arReady(arReady), .arAddr(arAddr),
		.rValid(rValid), .rReady(rReady), .rData(rData), .rResp(rResp)
	);

	//********************
	// Reporting
	task automatic reportMismatch(input string name, input logic [31:0] expVal,
		input logic [31:0] gotVal);
		$display("[FAIL] time %0d ns: %s expected %h, got %h", $time, name, expVal, gotVal);
		errCount++;
	endtask

	task automatic reportHang(input string what);
		$display("Timeout at %0d ns: %s", $time, what);
		hung = 1'b1;
		errCount++;
	endtask

	task automatic finishTest(input string name, input int errBefore);
		testCount++;
		if (errCount == errBefore)
			$display("Test %s: ok", name);
		else
		begin
			failCount++;
			$display("Test %s: %0d mismatches", name, errCount - errBefore);
		end
	endtask

	function automatic logic [7:0] regAddr(input logic [3:0] idx);
		return addrRegBase + {2'b00, idx, 2'b00};	// Word stride
	endfunction

	//********************
	// AXI4-Lite bus tasks
	task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int cnt;
		resp = 2'bxx;
		if (!hung)
		begin
			@(negedge clk);
			awAddr = addr;
			wData = data;
			awValid = 1'b1;
			wValid = 1'b1;
			cnt = 0;
			#1;
			while (!awReady && cnt < waitLimit)
			begin
				@(negedge clk);
				#1;
				cnt++;
			end
			if (!awReady)
				reportHang("write address and data were never accepted");
			else
			begin
				@(negedge clk);		// Handshake taken on the rising edge
				awValid = 1'b0;
				wValid = 1'b0;
				bReady = 1'b1;
				cnt = 0;
				#1;
				while (!bValid && cnt < waitLimit)
				begin
					@(negedge clk);
					#1;
					cnt++;
				end
				if (!bValid)
					reportHang("write response never arrived");
				else
				begin
					resp = bResp;
					@(negedge clk);
					bReady = 1'b0;
				end
			end
		end
	endtask

	task automatic axiRead(input logic [7:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int cnt;
		data = 'x;
		resp = 2'bxx;
		if (!hung)
		begin
			@(negedge clk);
			arAddr = addr;
			arValid = 1'b1;
			cnt = 0;
			#1;
			while (!arReady && cnt < waitLimit)
			begin
				@(negedge clk);
				#1;
				cnt++;
			end
			if (!arReady)
				reportHang("read address was never accepted");
			else
			begin
				@(negedge clk);
				arValid = 1'b0;
				rReady = 1'b1;
				cnt = 0;
				#1;
				while (!rValid && cnt < waitLimit)
				begin
					@(negedge clk);
					#1;
					cnt++;
				end
				if (!rValid)
					reportHang("read data never arrived");
				else
				begin
					data = rData;
					resp = rResp;
					@(negedge clk);
					rReady = 1'b0;
				end
			end
		end
	endtask

	task automatic writeReg(input logic [3:0] idx, input logic [31:0] val);
		logic [1:0] resp;
		axiWrite(regAddr(idx), val, resp);
		if (!hung && resp !== respOkay)
			reportMismatch($sformatf("bResp R%0d", idx), respOkay, resp);
		shadow[idx] = val;
	endtask

	task automatic checkAllRegs();
		logic [31:0] got;
		logic [1:0] resp;
		int r;
		for (r = 0; r < 16; r++)
		begin
			axiRead(regAddr(4'(r)), got, resp);
			if (!hung && resp !== respOkay)
				reportMismatch($sformatf("rResp R%0d", r), respOkay, resp);
			if (!hung && got !== shadow[r])
				reportMismatch($sformatf("R%0d", r), shadow[r], got);
		end
	endtask

	//********************
	// Stimulus table
	task automatic loadTable();
		// Arithmetic with Rm LSL #0
		tbl[0] = {32'h7FFF_FFFF, 32'h0000_0001, 4'h0, 2'b00, 1'b0, opAdd, 1'b1,
			12'h002, 32'h8000_0000, 4'h9, respOkay};		// Signed overflow
		tbl[1] = {32'hFFFF_FFFF, 32'h0000_0001, 4'h0, 2'b00, 1'b0, opAdd, 1'b1,
			12'h002, 32'h0000_0000, 4'h6, respOkay};		// Carry and zero
		tbl[2] = {32'h0000_0001, 32'h0000_0002, 4'h2, 2'b00, 1'b0, opAdc, 1'b1,
			12'h002, 32'h0000_0004, 4'h0, respOkay};
		tbl[3] = {32'h0000_0005, 32'h0000_0005, 4'h0, 2'b00, 1'b0, opSub, 1'b1,
			12'h002, 32'h0000_0000, 4'h6, respOkay};
		tbl[4] = {32'h0000_0003, 32'h0000_0005, 4'h0, 2'b00, 1'b0, opSub, 1'b1,
			12'h002, 32'hFFFF_FFFE, 4'h8, respOkay};		// Borrow clears C
		tbl[5] = {32'h8000_0000, 32'h0000_0001, 4'h0, 2'b00, 1'b0, opSub, 1'b1,
			12'h002, 32'h7FFF_FFFF, 4'h3, respOkay};
		tbl[6] = {32'h0000_000A, 32'h0000_0003, 4'h0, 2'b00, 1'b0, opSbc, 1'b1,
			12'h002, 32'h0000_0006, 4'h2, respOkay};		// C clear takes one more
		tbl[7] = {32'h0000_0003, 32'h0000_000A, 4'h0, 2'b00, 1'b0, opRsb, 1'b1,
			12'h002, 32'h0000_0007, 4'h2, respOkay};
		tbl[8] = {32'h0000_000A, 32'h0000_0003, 4'h2, 2'b00, 1'b0, opRsc, 1'b1,
			12'h002, 32'hFFFF_FFF9, 4'h8, respOkay};
		tbl[9] = {32'h0000_0100, 32'h0000_0000, 4'h0, 2'b00, 1'b1, opAdd, 1'b1,
			12'h0FF, 32'h0000_01FF, 4'h0, respOkay};
		// Logical ops through each shifter mode
		tbl[10] = {32'hF0F0_F0F0, 32'h1F00_000F, 4'h1, 2'b00, 1'b0, opAnd, 1'b1,
			12'h202, 32'hF000_00F0, 4'hB, respOkay};		// LSL #4
		tbl[11] = {32'h1234_5678, 32'h8000_0000, 4'h0, 2'b00, 1'b0, opEor, 1'b1,
			12'h022, 32'h1234_5678, 4'h2, respOkay};		// LSR #32
		tbl[12] = {32'h0000_0001, 32'h8000_1000, 4'h3, 2'b00, 1'b0, opOrr, 1'b1,
			12'h442, 32'hFF80_0011, 4'h9, respOkay};		// ASR #8
		tbl[13] = {32'hFFFF_FFFF, 32'h0000_000F, 4'h0, 2'b00, 1'b0, opBic, 1'b1,
			12'h262, 32'h0FFF_FFFF, 4'h2, respOkay};		// ROR #4
		tbl[14] = {32'h0000_0000, 32'h0000_0003, 4'h2, 2'b00, 1'b0, opMov, 1'b1,
			12'h062, 32'h8000_0001, 4'hA, respOkay};		// RRX
		tbl[15] = {32'h0000_0000, 32'h0000_0000, 4'h0, 2'b00, 1'b1, opMvn, 1'b1,
			12'h4FF, 32'h00FF_FFFF, 4'h2, respOkay};		// 0xFF ror 8
		tbl[16] = {32'h0000_0000, 32'h0000_0000, 4'h3, 2'b00, 1'b1, opMov, 1'b1,
			12'h000, 32'h0000_0000, 4'h7, respOkay};		// Rotate 0 keeps C
		// Compares
		tbl[17] = {32'h0000_00F0, 32'h0000_000F, 4'h0, 2'b00, 1'b0, opTst, 1'b1,
			12'h002, rdInit, 4'h4, respOkay};
		tbl[18] = {32'h8000_0000, 32'h0000_0001, 4'h1, 2'b00, 1'b0, opTeq, 1'b1,
			12'h002, rdInit, 4'h9, respOkay};
		tbl[19] = {32'h0000_0001, 32'h0000_0002, 4'h6, 2'b00, 1'b0, opCmp, 1'b0,
			12'h002, rdInit, 4'h8, respOkay};				// S clear still sets flags
		tbl[20] = {32'hFFFF_FFFF, 32'h0000_0001, 4'h0, 2'b00, 1'b0, opCmn, 1'b1,
			12'h002, rdInit, 4'h6, respOkay};
		// Flags hold with S clear
		tbl[21] = {32'h7FFF_FFFF, 32'h0000_0001, 4'h5, 2'b00, 1'b0, opAdd, 1'b0,
			12'h002, 32'h8000_0000, 4'h5, respOkay};
		tbl[22] = {32'h0000_0000, 32'h0000_0000, 4'hA, 2'b00, 1'b1, opMov, 1'b0,
			12'h0AB, 32'h0000_00AB, 4'hA, respOkay};
		// Refused words
		tbl[23] = {32'h0000_0001, 32'h0000_0002, 4'h3, 2'b01, 1'b0, opAdd, 1'b1,
			12'h002, rdInit, 4'h3, respSlvErr};			// Not data processing
		tbl[24] = {32'h0000_0001, 32'h0000_0002, 4'hC, 2'b00, 1'b0, opAdd, 1'b1,
			12'h012, rdInit, 4'hC, respSlvErr};			// Register-specified shift
	endtask

	//********************
	// Tests
	task automatic testRegAccess();
		logic [31:0] got;
		logic [1:0] resp;
		int errBefore;
		int r;
		errBefore = errCount;
		checkAllRegs();		// All zero out of reset
		axiRead(addrStatus, got, resp);
		if (!hung && resp !== respOkay)
			reportMismatch("rResp STATUS", respOkay, resp);
		if (!hung && got !== 32'h0)
			reportMismatch("STATUS", 32'h0, got);
		finishTest("reset values", errBefore);

		errBefore = errCount;
		for (r = 0; r < 16; r++)
			writeReg(4'(r), $random(seed));
		checkAllRegs();
		finishTest("register file", errBefore);

		errBefore = errCount;
		axiWrite(addrStatus, 32'hA000_0000, resp);
		if (!hung && resp !== respOkay)
			reportMismatch("bResp STATUS", respOkay, resp);
		axiRead(addrStatus, got, resp);
		if (!hung && resp !== respOkay)
			reportMismatch("rResp STATUS", respOkay, resp);
		if (!hung && got !== 32'hA000_0000)
			reportMismatch("STATUS", 32'hA000_0000, got);
		axiWrite(addrStatus, 32'h5FFF_FFFF, resp);
		if (!hung && resp !== respOkay)
			reportMismatch("bResp STATUS", respOkay, resp);
		axiRead(addrStatus, got, resp);
		if (!hung && resp !== respOkay)
			reportMismatch("rResp STATUS", respOkay, resp);
		if (!hung && got !== 32'h5000_0000)		// Only NZCV kept
			reportMismatch("STATUS", 32'h5000_0000, got);
		finishTest("status flags", errBefore);

		errBefore = errCount;
		axiRead(8'h08, got, resp);
		if (!hung && resp !== respSlvErr)
			reportMismatch("rResp", respSlvErr, resp);
		if (!hung && got !== 32'h0)
			reportMismatch("rData", 32'h0, got);
		axiWrite(8'h10, 32'hFFFF_FFFF, resp);
		if (!hung && resp !== respSlvErr)
			reportMismatch("bResp", respSlvErr, resp);
		checkAllRegs();		// Unmapped write changes nothing
		finishTest("unmapped access", errBefore);
	endtask

	task automatic runVector(input int idx);
		vec_t v;
		logic [31:0] word;
		logic [31:0] got;
		logic [1:0] resp;
		int errBefore;
		v = tbl[idx];
		errBefore = errCount;
		writeReg(rnIdx, v.rnVal);
		writeReg(rmIdx, v.rmVal);
		writeReg(rdIdx, rdInit);
		axiWrite(addrStatus, {v.nzcvIn, 28'h0}, resp);
		if (!hung && resp !== respOkay)
			reportMismatch("bResp STATUS", respOkay, resp);
		word = {4'hE, v.fixed, v.iBit, v.op, v.sBit, rnIdx, rdIdx, v.op2};	// Cond AL
		axiWrite(addrInstr, word, resp);
		if (!hung && resp !== v.expResp)
			reportMismatch("bResp", v.expResp, resp);
		axiRead(regAddr(rdIdx), got, resp);
		if (!hung && resp !== respOkay)
			reportMismatch($sformatf("rResp R%0d", rdIdx), respOkay, resp);
		if (!hung && got !== v.expRd)
			reportMismatch($sformatf("R%0d", rdIdx), v.expRd, got);
		axiRead(addrStatus, got, resp);
		if (!hung && resp !== respOkay)
			reportMismatch("rResp STATUS", respOkay, resp);
		if (!hung && got !== {v.expNzcv, 28'h0})
			reportMismatch("STATUS", {v.expNzcv, 28'h0}, got);
		shadow[rdIdx] = v.expRd;
		if (v.expResp == respSlvErr)
			checkAllRegs();		// Refused word leaves every register alone
		finishTest($sformatf("vector %0d op %h", idx, v.op), errBefore);
	endtask

	//********************
	// Main sequence
	initial
	begin
		awValid = 1'b0;
		awAddr = '0;
		wValid = 1'b0;
		wData = '0;
		wStrb = 4'hF;
		bReady = 1'b0;
		arValid = 1'b0;
		arAddr = '0;
		rReady = 1'b0;
		seed = 81077;
		hung = 1'b0;
		errCount = 0;
		testCount = 0;
		failCount = 0;
		for (vecIdx = 0; vecIdx < 16; vecIdx++)
			shadow[vecIdx] = '0;
		loadTable();

		rstWait = 0;
		while (arstN !== 1'b1 && rstWait < waitLimit)
		begin
			@(negedge clk);
			rstWait++;
		end
		if (arstN !== 1'b1)
			reportHang("reset was never released");

		testRegAccess();
		for (vecIdx = 0; vecIdx < numVec && !hung; vecIdx++)
			runVector(vecIdx);

		$display("Tests: %0d, failed: %0d, mismatches: %0d", testCount, failCount, errCount);
		if (errCount == 0 && !hung)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- project.f
rtl/armExecPkg.sv
rtl/armShifter.sv
rtl/armAlu.sv
rtl/armRegFile.sv
rtl/armExecCore.sv
rtl/armAxiSlave.sv
rtl/armExecUnit.sv
dv/tbClock.sv
dv/armExecTb.sv

//--- Bender.yml
package:
  name: arm_exec_unit

sources:
  - files:
      - rtl/armExecPkg.sv
      - rtl/armShifter.sv
      - rtl/armAlu.sv
      - rtl/armRegFile.sv
      - rtl/armExecCore.sv
      - rtl/armAxiSlave.sv
      - rtl/armExecUnit.sv
  - target: test
    files:
      - dv/tbClock.sv
      - dv/armExecTb.sv
